// ==== check_extrema.f ====
hw/extrema_pkg.sv
hw/window_if.sv
hw/pixel_reader.sv
hw/window_fetch.sv
hw/extremum_compare.sv
hw/keypoint_writer.sv
hw/check_extrema.sv
bench/check_extrema_asserts.sv
bench/check_extrema_tb.sv

// ==== Bender.yml ====
package:
  name: check_extrema

sources:
  - files:
      - hw/extrema_pkg.sv
      - hw/window_if.sv
      - hw/pixel_reader.sv
      - hw/window_fetch.sv
      - hw/extremum_compare.sv
      - hw/keypoint_writer.sv
      - hw/check_extrema.sv
  - target: test
    files:
      - bench/check_extrema_asserts.sv
      - bench/check_extrema_tb.sv

// ==== bench/check_extrema_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module check_extrema_tb;
  import extrema_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int NUM_ROWS = 8;
  localparam int NUM_PIXELS = IMG_DIM * IMG_DIM;
  localparam int INTERIOR = LAST_INNER * LAST_INNER;
  // nine reads of about four cycles for every interior pixel
  localparam int WORST_SCAN = 9 * 4 * INTERIOR;
  localparam int WATCHDOG_CYCLES = NUM_ROWS * WORST_SCAN * 2 + 100;

  localparam int FILL_FLAT = 0;
  localparam int FILL_RANDOM = 1;
  localparam int FILL_KEEP = 2;
  localparam int COMPUTED = -1;
  localparam int FLAT_VALUE = 5;

  // x of 0 means nothing is planted
  typedef struct packed {
    int fill;
    int first_x;
    int first_y;
    int first_val;
    int second_x;
    int second_y;
    int second_val;
    int count;
  } test_row_t;

  logic clk;
  logic rst_in;
  logic enable;
  pixel_t first_data;
  pixel_t second_data;
  addr_t first_address;
  addr_t second_address;
  logic key_wea;
  logic done_checking;
  key_t key_out;

  pixel_t first_mem [NUM_PIXELS];
  pixel_t second_mem [NUM_PIXELS];
  test_row_t test_table [NUM_ROWS];
  logic [15:0] lfsr_state;
  key_t got_keys [$];
  key_t exp_keys [$];
  logic scan_finished;

  check_extrema dut_i (
    .clk           (clk),
    .rst_in        (rst_in),
    .enable        (enable),
    .first_data    (first_data),
    .second_data   (second_data),
    .first_address (first_address),
    .second_address(second_address),
    .key_wea       (key_wea),
    .done_checking (done_checking),
    .key_out       (key_out)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // BRAM models with one registered read cycle
  always @(posedge clk) begin
    first_data <= first_mem[first_address];
    second_data <= second_mem[second_address];
  end

  task automatic check_equal(input string name, input logic signed [31:0] actual,
                             input logic signed [31:0] expected);
    if (actual !== expected) begin
      $display("Error at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
      $display("Some tests failed");
      $fatal(1);
    end
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic draw_pixel(output pixel_t p);
    for (int b = 0; b < PIXEL_BITS; b++) begin
      lfsr_state = lfsr_step(lfsr_state);
      p[b] = lfsr_state[0];
    end
  endtask

  task automatic fill_images(input test_row_t row);
    pixel_t p;
    if (row.fill != FILL_KEEP) begin
      for (int a = 0; a < NUM_PIXELS; a++) begin
        if (row.fill == FILL_RANDOM) begin
          draw_pixel(p);
          first_mem[a] = p;
          draw_pixel(p);
          second_mem[a] = p;
        end else begin
          first_mem[a] = pixel_t'(FLAT_VALUE);
          second_mem[a] = pixel_t'(FLAT_VALUE);
        end
      end
    end
    if (row.first_x != 0)
      first_mem[row.first_y * IMG_DIM + row.first_x] = pixel_t'(row.first_val);
    if (row.second_x != 0)
      second_mem[row.second_y * IMG_DIM + row.second_x] = pixel_t'(row.second_val);
  endtask

  function automatic pixel_t pixel_at(input int img, input int x, input int y);
    return (img == 0) ? first_mem[y * IMG_DIM + x] : second_mem[y * IMG_DIM + x];
  endfunction

  // strictly above or below all 17 other values of the 3x3x2 block
  function automatic logic is_peak(input int img, input int x, input int y);
    pixel_t c;
    logic above;
    logic below;
    c = pixel_at(img, x, y);
    above = 1'b1;
    below = 1'b1;
    for (int i = 0; i < 2; i++)
      for (int dy = -1; dy <= 1; dy++)
        for (int dx = -1; dx <= 1; dx++)
          if (!(i == img && dx == 0 && dy == 0)) begin
            above = above && (c > pixel_at(i, x + dx, y + dy));
            below = below && (c < pixel_at(i, x + dx, y + dy));
          end
    return above || below;
  endfunction

  task automatic build_expected();
    exp_keys.delete();
    for (int y = 1; y <= LAST_INNER; y++)
      for (int x = 1; x <= LAST_INNER; x++)
        for (int img = 0; img < 2; img++)
          if (is_peak(img, x, y))
            exp_keys.push_back({coord_t'(x), coord_t'(y), img == 1});
    // end marker
    exp_keys.push_back('0);
  endtask

  task automatic run_scan();
    got_keys.delete();
    scan_finished = 1'b0;
    @(posedge clk);
    enable <= 1'b1;
    @(posedge clk);
    enable <= 1'b0;
    wait (scan_finished);
  endtask

  // outputs are sampled half a cycle after they change
  always @(negedge clk) begin
    if (!rst_in && key_wea)
      got_keys.push_back(key_out);
    if (!rst_in && done_checking) begin
      check_equal("key_wea", key_wea, 1);
      check_equal("key_out", key_out, 0);
      scan_finished = 1'b1;
    end
  end

  initial begin
    rst_in = 1'b1;
    enable = 1'b0;
    first_data = '0;
    second_data = '0;
    lfsr_state = 16'd44;
    scan_finished = 1'b0;
    // fill, first (x, y, value), second (x, y, value), keypoints
    test_table = '{
      '{FILL_FLAT,   0, 0, 0,   0, 0, 0,    0},
      '{FILL_FLAT,   3, 4, 100, 0, 0, 0,    1},
      '{FILL_FLAT,   0, 0, 0,   5, 2, -200, 1},
      '{FILL_FLAT,   2, 3, 120, 2, 3, -150, 2},
      '{FILL_FLAT,   1, 1, 50,  6, 6, -50,  2},
      '{FILL_RANDOM, 0, 0, 0,   0, 0, 0,    COMPUTED},
      '{FILL_RANDOM, 0, 0, 0,   0, 0, 0,    COMPUTED},
      '{FILL_KEEP,   0, 0, 0,   0, 0, 0,    COMPUTED}
    };
    repeat (4) @(posedge clk);
    rst_in <= 1'b0;
    // both BRAM addresses come out of reset at zero
    @(negedge clk);
    check_equal("first_address", first_address, 0);
    check_equal("second_address", second_address, 0);
    for (int r = 0; r < NUM_ROWS; r++) begin
      fill_images(test_table[r]);
      build_expected();
      if (test_table[r].count != COMPUTED)
        check_equal("model key count", exp_keys.size() - 1, test_table[r].count);
      run_scan();
      check_equal("key write count", got_keys.size(), exp_keys.size());
      for (int k = 0; k < exp_keys.size(); k++)
        check_equal($sformatf("key_out[%0d]", k), got_keys[k], exp_keys[k]);
      $display("row %0d done with %0d keypoints", r, exp_keys.size() - 1);
    end
    $display("All tests passed");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the scans did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Some tests failed");
    $fatal(1);
  end

endmodule

`default_nettype wire

// ==== bench/check_extrema_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module check_extrema_asserts (
  input logic clk,
  input logic rst_in,
  input logic key_wea,
  input logic done_checking,
  input extrema_pkg::key_t key_out
);

  // every write strobe lasts a single cycle
  property single_cycle_write;
    @(posedge clk) disable iff (rst_in) key_wea |=> !key_wea;
  endproperty

  // end marker is a zero word written together with done_checking
  property end_marker;
    @(posedge clk) disable iff (rst_in) done_checking |-> (key_wea && key_out == '0);
  endproperty

  property quiet_after_reset;
    @(posedge clk) rst_in |=> (!key_wea && !done_checking);
  endproperty

  assert property (single_cycle_write) else $error("key_wea high for two cycles");
  assert property (end_marker) else $error("done_checking without a zero key write");
  assert property (quiet_after_reset) else $error("strobe high right after reset");

endmodule

bind check_extrema check_extrema_asserts asserts_i (
  .clk          (clk),
  .rst_in       (rst_in),
  .key_wea      (key_wea),
  .done_checking(done_checking),
  .key_out      (key_out)
);

`default_nettype wire

// ==== hw/check_extrema.sv ====
`timescale 1ns/1ps
`default_nettype none

module check_extrema (
  input  logic clk,
  input  logic rst_in,
  input  logic enable,
  input  extrema_pkg::pixel_t first_data,
  input  extrema_pkg::pixel_t second_data,
  output extrema_pkg::addr_t first_address,
  output extrema_pkg::addr_t second_address,
  output logic key_wea,
  output logic done_checking,
  output extrema_pkg::key_t key_out
);
  import extrema_pkg::*;

  // fetch to reader
  logic read_req;
  logic read_done;
  coord_t rx;
  coord_t ry;

  // compare to writer
  logic hit_strobe;
  logic first_hit;
  logic second_hit;
  coord_t hx;
  coord_t hy;

  window_if win_bus ();

  pixel_reader reader_i (
    .clk           (clk),
    .rst_in        (rst_in),
    .read_req      (read_req),
    .rx            (rx),
    .ry            (ry),
    .first_address (first_address),
    .second_address(second_address),
    .read_done     (read_done)
  );

  window_fetch fetch_i (
    .clk        (clk),
    .rst_in     (rst_in),
    .enable     (enable),
    .read_req   (read_req),
    .rx         (rx),
    .ry         (ry),
    .read_done  (read_done),
    .first_data (first_data),
    .second_data(second_data),
    .win        (win_bus.fetch)
  );

  extremum_compare compare_i (
    .clk       (clk),
    .rst_in    (rst_in),
    .win       (win_bus.compare),
    .hit_strobe(hit_strobe),
    .first_hit (first_hit),
    .second_hit(second_hit),
    .hx        (hx),
    .hy        (hy)
  );

  keypoint_writer writer_i (
    .clk          (clk),
    .rst_in       (rst_in),
    .hit_strobe   (hit_strobe),
    .first_hit    (first_hit),
    .second_hit   (second_hit),
    .hx           (hx),
    .hy           (hy),
    .win          (win_bus.writer),
    .key_wea      (key_wea),
    .key_out      (key_out),
    .done_checking(done_checking)
  );

endmodule

`default_nettype wire

// ==== hw/keypoint_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module keypoint_writer (
  input  logic clk,
  input  logic rst_in,
  input  logic hit_strobe,
  input  logic first_hit,
  input  logic second_hit,
  input  extrema_pkg::coord_t hx,
  input  extrema_pkg::coord_t hy,
  window_if.writer win,
  output logic key_wea,
  output extrema_pkg::key_t key_out,
  output logic done_checking
);
  import extrema_pkg::*;

  writer_state_t state;

  // scan ended while a write was still in progress
  logic end_pending;

  always_ff @(posedge clk) begin
    if (rst_in) begin
      state <= WR_IDLE;
      end_pending <= 1'b0;
      key_wea <= 1'b0;
      key_out <= '0;
      done_checking <= 1'b0;
    end else begin
      key_wea <= 1'b0;
      done_checking <= 1'b0;
      if (win.scan_done) begin
        end_pending <= 1'b1;
      end
      case (state)
        WR_IDLE: begin
          if (hit_strobe) begin
            // image 0 goes first when both centres are extrema
            key_wea <= 1'b1;
            key_out <= {hx, hy, !first_hit};
            state <= (first_hit && second_hit) ? WR_SECOND : WR_FINISH;
          end else if (end_pending || win.scan_done) begin
            // all-zero end marker
            key_wea <= 1'b1;
            key_out <= '0;
            done_checking <= 1'b1;
            end_pending <= 1'b0;
            state <= WR_WRAP_UP;
          end
        end
        WR_SECOND: begin
          // one low cycle between the two writes
          if (!key_wea) begin
            key_wea <= 1'b1;
            key_out[0] <= 1'b1;
            state <= WR_FINISH;
          end
        end
        WR_FINISH: state <= WR_IDLE;
        WR_WRAP_UP: state <= WR_IDLE;
        default: state <= WR_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/extremum_compare.sv ====
`timescale 1ns/1ps
`default_nettype none

module extremum_compare (
  input  logic clk,
  input  logic rst_in,
  window_if.compare win,
  output logic hit_strobe,
  output logic first_hit,
  output logic second_hit,
  output extrema_pkg::coord_t hx,
  output extrema_pkg::coord_t hy
);
  import extrema_pkg::*;

  logic first_ext;
  logic second_ext;

  // strict signed test of the own centre against 8 own and 9 other values
  function automatic logic is_extremum(input pixel_t own [WIN_SIZE],
                                       input pixel_t other [WIN_SIZE]);
    pixel_t centre;
    logic above;
    logic below;
    centre = own[NB_MIDDLE];
    above = 1'b1;
    below = 1'b1;
    for (int i = 0; i < WIN_SIZE; i++) begin
      if (i != int'(NB_MIDDLE)) begin
        above &= (centre > own[i]);
        below &= (centre < own[i]);
      end
      above &= (centre > other[i]);
      below &= (centre < other[i]);
    end
    return above || below;
  endfunction

  assign first_ext = is_extremum(win.first_win, win.second_win);
  assign second_ext = is_extremum(win.second_win, win.first_win);

  always_ff @(posedge clk) begin
    if (rst_in) begin
      hit_strobe <= 1'b0;
    end else begin
      // only checks that found something are passed on
      hit_strobe <= win.check_strobe && (first_ext || second_ext);
    end
  end

  always_ff @(posedge clk) begin
    if (win.check_strobe) begin
      first_hit <= first_ext;
      second_hit <= second_ext;
      hx <= win.cx;
      hy <= win.cy;
    end
  end

endmodule

`default_nettype wire

// ==== hw/window_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module window_fetch (
  input  logic clk,
  input  logic rst_in,
  input  logic enable,
  output logic read_req,
  output extrema_pkg::coord_t rx,
  output extrema_pkg::coord_t ry,
  input  logic read_done,
  input  extrema_pkg::pixel_t first_data,
  input  extrema_pkg::pixel_t second_data,
  window_if.fetch win
);
  import extrema_pkg::*;

  scan_state_t state;
  neighbor_t pos;
  neighbor_t next_pos;
  logic shift_now;

  // neighbour coordinates relative to the current centre
  always_comb begin
    case (pos)
      NB_TOP_LEFT, NB_LEFT, NB_BOT_LEFT: rx = win.cx - 1'b1;
      NB_TOP_RIGHT, NB_RIGHT, NB_BOT_RIGHT: rx = win.cx + 1'b1;
      default: rx = win.cx;
    endcase
    case (pos)
      NB_TOP_LEFT, NB_TOP, NB_TOP_RIGHT: ry = win.cy - 1'b1;
      NB_BOT_LEFT, NB_BOT, NB_BOT_RIGHT: ry = win.cy + 1'b1;
      default: ry = win.cy;
    endcase
  end

  // a row load walks all nine positions, a shift only the right column
  assign next_pos = (state == SCAN_SHIFT_RIGHT) ? neighbor_t'(pos + WIN_SIDE)
                                                : neighbor_t'(pos + 1);

  assign shift_now = (state == SCAN_SHIFT_RIGHT) && (pos == NB_NONE);

  // window registers
  always_ff @(posedge clk) begin
    if (shift_now) begin
      // move the middle and right columns one place left
      for (int r = 0; r < WIN_SIDE; r++) begin
        win.first_win[r*WIN_SIDE] <= win.first_win[r*WIN_SIDE + 1];
        win.first_win[r*WIN_SIDE + 1] <= win.first_win[r*WIN_SIDE + 2];
        win.second_win[r*WIN_SIDE] <= win.second_win[r*WIN_SIDE + 1];
        win.second_win[r*WIN_SIDE + 1] <= win.second_win[r*WIN_SIDE + 2];
      end
    end else if (read_done && pos != NB_NONE) begin
      win.first_win[pos] <= first_data;
      win.second_win[pos] <= second_data;
    end
  end

  // scan FSM
  always_ff @(posedge clk) begin
    if (rst_in) begin
      state <= SCAN_IDLE;
      pos <= NB_NONE;
      read_req <= 1'b0;
      win.cx <= coord_t'(1);
      win.cy <= coord_t'(1);
      win.check_strobe <= 1'b0;
      win.scan_done <= 1'b0;
    end else begin
      read_req <= 1'b0;
      win.check_strobe <= 1'b0;
      win.scan_done <= 1'b0;
      case (state)
        SCAN_IDLE: begin
          if (enable) begin
            win.cx <= coord_t'(1);
            win.cy <= coord_t'(1);
            pos <= NB_TOP_LEFT;
            read_req <= 1'b1;
            state <= SCAN_LOAD_ROW;
          end
        end
        SCAN_LOAD_ROW, SCAN_SHIFT_RIGHT: begin
          if (shift_now) begin
            pos <= NB_TOP_RIGHT;
            read_req <= 1'b1;
          end else if (read_done) begin
            // bottom right is the last read in both walks
            if (pos == NB_BOT_RIGHT) begin
              pos <= NB_NONE;
              win.check_strobe <= 1'b1;
              state <= SCAN_CHECK;
            end else begin
              pos <= next_pos;
              read_req <= 1'b1;
            end
          end
        end
        SCAN_CHECK: begin
          // compare samples the window during this cycle
          state <= SCAN_ADVANCE;
        end
        SCAN_ADVANCE: begin
          if (win.cx < coord_t'(LAST_INNER)) begin
            win.cx <= win.cx + 1'b1;
            state <= SCAN_SHIFT_RIGHT;
          end else if (win.cy < coord_t'(LAST_INNER)) begin
            win.cx <= coord_t'(1);
            win.cy <= win.cy + 1'b1;
            pos <= NB_TOP_LEFT;
            read_req <= 1'b1;
            state <= SCAN_LOAD_ROW;
          end else begin
            win.scan_done <= 1'b1;
            state <= SCAN_IDLE;
          end
        end
        default: state <= SCAN_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/pixel_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_reader (
  input  logic clk,
  input  logic rst_in,
  input  logic read_req,
  input  extrema_pkg::coord_t rx,
  input  extrema_pkg::coord_t ry,
  output extrema_pkg::addr_t first_address,
  output extrema_pkg::addr_t second_address,
  output logic read_done
);
  import extrema_pkg::*;

  addr_t req_addr;
  logic busy;
  logic [WAIT_BITS-1:0] wait_cnt;

  // both images are read at the same row-major address
  assign req_addr = addr_t'(ry * IMG_DIM + rx);

  always_ff @(posedge clk) begin
    if (rst_in) begin
      first_address <= '0;
      second_address <= '0;
      busy <= 1'b0;
      wait_cnt <= '0;
      read_done <= 1'b0;
    end else begin
      read_done <= 1'b0;
      if (busy) begin
        // count down the fixed BRAM latency
        if (wait_cnt == '0) begin
          busy <= 1'b0;
          read_done <= 1'b1;
        end else begin
          wait_cnt <= wait_cnt - 1'b1;
        end
      end else if (read_req) begin
        first_address <= req_addr;
        second_address <= req_addr;
        wait_cnt <= WAIT_BITS'(READ_WAIT - 1);
        busy <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/window_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface window_if;
  import extrema_pkg::*;

  // both neighbourhoods, indexed by neighbor_t
  pixel_t first_win [WIN_SIZE];
  pixel_t second_win [WIN_SIZE];

  // centre of the current window
  coord_t cx;
  coord_t cy;

  logic check_strobe;
  logic scan_done;

  modport fetch (
    output first_win, second_win, cx, cy, check_strobe, scan_done
  );

  modport compare (
    input first_win, second_win, cx, cy, check_strobe
  );

  modport writer (
    input scan_done
  );

endinterface

`default_nettype wire

// ==== hw/extrema_pkg.sv ====
`default_nettype none

package extrema_pkg;

  // image geometry
  localparam int IMG_DIM = 8;
  localparam int PIXEL_BITS = 9;
  localparam int COORD_BITS = $clog2(IMG_DIM);
  localparam int ADDR_BITS = $clog2(IMG_DIM * IMG_DIM);

  // interior scan runs from 1 up to this coordinate on both axes
  localparam int LAST_INNER = IMG_DIM - 2;

  // cycles from registered address to valid BRAM data
  localparam int READ_WAIT = 3;
  localparam int WAIT_BITS = $clog2(READ_WAIT + 1);

  // 3x3 neighbourhood
  localparam int WIN_SIDE = 3;
  localparam int WIN_SIZE = WIN_SIDE * WIN_SIDE;

  typedef logic signed [PIXEL_BITS-1:0] pixel_t;
  typedef logic [COORD_BITS-1:0] coord_t;
  typedef logic [ADDR_BITS-1:0] addr_t;

  // {x, y, image bit}
  typedef logic [2*COORD_BITS:0] key_t;

  // window positions in row-major order, so the value is the window index
  typedef enum logic [3:0] {
    NB_TOP_LEFT, NB_TOP, NB_TOP_RIGHT,
    NB_LEFT, NB_MIDDLE, NB_RIGHT,
    NB_BOT_LEFT, NB_BOT, NB_BOT_RIGHT,
    NB_NONE
  } neighbor_t;

  typedef enum logic [2:0] {
    SCAN_IDLE, SCAN_LOAD_ROW, SCAN_CHECK, SCAN_ADVANCE, SCAN_SHIFT_RIGHT
  } scan_state_t;

  typedef enum logic [1:0] {
    WR_IDLE, WR_SECOND, WR_FINISH, WR_WRAP_UP
  } writer_state_t;

endpackage

`default_nettype wire
